/* hdl/cpuPkg.sv */
// cpu package
// shared types for the 8-bit accumulator datapath: commands, decoded control,
// status flags and the ALU result, plus the status reset value

package cpuPkg;

    typedef logic [7:0] dataWord;

    // pre-decoded command kinds, no real opcode decoding is done
    typedef enum logic [4:0] {
        opNop,
        opAdc,
        opAnd,
        opEor,
        opOra,
        opLsr,
        opLda,
        opLdx,
        opLdy,
        opTax,
        opTay,
        opTxa,
        opTya,
        opSec,
        opClc,
        opSed,
        opCld,
        opJmp
    } opKind;

    typedef struct packed {
        opKind   op;
        dataWord operand;
    } cmdWord;

    typedef enum logic [2:0] {aluAdd, aluAnd, aluEor, aluOr, aluLsr, aluPass} aluOp;

    typedef enum logic [1:0] {destNone, destA, destX, destY} regSel;

    typedef enum logic [1:0] {srcA, srcX, srcY, srcZero} srcSel;

    // flag update mask, set and clear bits win over the update bits
    typedef struct packed {
        logic updNZ;
        logic updC;
        logic updV;
        logic setC;
        logic clrC;
        logic setD;
        logic clrD;
    } flagCtrl;

    typedef struct packed {
        aluOp    alu;
        srcSel   src;
        regSel   dest;
        flagCtrl flags;
        logic    pcLoad;
    } ctrlWord;

    // 6502 bit order NV1BDIZC
    typedef struct packed {
        logic n;
        logic v;
        logic one;
        logic b;
        logic d;
        logic i;
        logic z;
        logic c;
    } statusFlags;

    typedef union packed {
        dataWord    raw;
        statusFlags flags;
    } statusWord;

    typedef struct packed {
        dataWord value;
        logic    carry;
        logic    overflow;
    } aluResult;

    localparam dataWord statusReset = 8'h20;

endpackage

/* hdl/arithUnit.sv */
// arithmetic unit
// binary add with carry, logic ops and shift right, with decimal add adjust
// when the D flag is set; the result and its flags are registered on execEn

`timescale 1ns/1ns

module arithUnit (
    input  logic              rstAll,
    input  logic              reset,
    input  logic              execEn,
    input  cpuPkg::aluOp      op,
    input  cpuPkg::dataWord   aSide,
    input  cpuPkg::dataWord   operand,
    input  cpuPkg::statusWord status,
    output cpuPkg::aluResult  result
);
    import cpuPkg::*;

    logic [4:0] lowSum;
    logic [4:0] highSum;
    logic       halfCarry;
    dataWord    binSum;
    logic       binCarry;
    logic       binOverflow;
    dataWord    adjSum;
    logic       decCarry;
    aluResult   nextResult;

    // add in two nibble steps so the half carry is available
    always_comb begin
        lowSum      = {1'b0, aSide[3:0]} + {1'b0, operand[3:0]} + {4'b0000, status.flags.c};
        halfCarry   = lowSum[4];
        highSum     = {1'b0, aSide[7:4]} + {1'b0, operand[7:4]} + {4'b0000, halfCarry};
        binSum      = {highSum[3:0], lowSum[3:0]};
        binCarry    = highSum[4];
        binOverflow = (aSide[7] == operand[7]) && (binSum[7] != aSide[7]);
    end

    // decimal adjust, V is kept from the binary sum
    always_comb begin
        adjSum   = binSum;
        decCarry = binCarry || (binSum > 8'h99);
        if ((binSum[3:0] > 4'd9) || halfCarry) begin
            adjSum = adjSum + 8'h06;
        end
        if (decCarry) begin
            adjSum = adjSum + 8'h60;
        end
    end

    always_comb begin
        nextResult = '0;
        case (op)
            aluAdd: begin
                nextResult.value    = status.flags.d ? adjSum : binSum;
                nextResult.carry    = status.flags.d ? decCarry : binCarry;
                nextResult.overflow = binOverflow;
            end
            aluAnd:  nextResult.value = aSide & operand;
            aluEor:  nextResult.value = aSide ^ operand;
            aluOr:   nextResult.value = aSide | operand;
            aluLsr: begin
                // zero shifted in, old bit 0 goes to carry
                nextResult.value = {1'b0, aSide[7:1]};
                nextResult.carry = aSide[0];
            end
            // transfers move the selected register unchanged
            default: nextResult.value = aSide;
        endcase
    end

    always_ff @(posedge rstAll) begin
        if (reset) begin
            result <= '0;
        end else if (execEn) begin
            result <= nextResult;
        end
    end

endmodule

/* hdl/dataRegs.sv */
// data registers
// accumulator, X, Y and the operand latch; selects the ALU A-side source
// and writes the ALU result into the destination register on commit

`timescale 1ns/1ns

module dataRegs (
    input  logic             rstAll,
    input  logic             reset,
    input  logic             latchOp,
    input  logic             commit,
    input  cpuPkg::dataWord  operandIn,
    input  cpuPkg::ctrlWord  ctrl,
    input  cpuPkg::aluResult result,
    output cpuPkg::dataWord  aSide,
    output cpuPkg::dataWord  operand,
    output cpuPkg::dataWord  accOut,
    output cpuPkg::dataWord  xOut,
    output cpuPkg::dataWord  yOut
);
    import cpuPkg::*;

    // A-side mux, zero lets a load pass the operand through an OR
    always_comb begin
        case (ctrl.src)
            srcA:    aSide = accOut;
            srcX:    aSide = xOut;
            srcY:    aSide = yOut;
            default: aSide = '0;
        endcase
    end

    // operand latch also feeds the jump target
    always_ff @(posedge rstAll) begin
        if (latchOp) begin
            operand <= operandIn;
        end
    end

    always_ff @(posedge rstAll) begin
        if (reset) begin
            accOut <= '0;
            xOut   <= '0;
            yOut   <= '0;
        end else if (commit) begin
            case (ctrl.dest)
                destA:   accOut <= result.value;
                destX:   xOut   <= result.value;
                destY:   yOut   <= result.value;
                // flag and jump commands write no register
                default: ;
            endcase
        end
    end

endmodule

/* hdl/statusReg.sv */
// status register
// updates N, Z, C and V from the ALU result under the flag mask,
// and handles the explicit set and clear of C and D

`timescale 1ns/1ns

module statusReg (
    input  logic              rstAll,
    input  logic              reset,
    input  logic              commit,
    input  cpuPkg::flagCtrl   flags,
    input  cpuPkg::aluResult  result,
    output cpuPkg::statusWord status
);
    import cpuPkg::*;

    logic resultZero;

    assign resultZero = (result.value == 8'h00);

    always_ff @(posedge rstAll) begin
        if (reset) begin
            status.raw <= statusReset;
        end else if (commit) begin
            if (flags.updNZ) begin
                status.flags.n <= result.value[7];
                status.flags.z <= resultZero;
            end
            if (flags.updC) begin
                status.flags.c <= result.carry;
            end
            if (flags.updV) begin
                status.flags.v <= result.overflow;
            end

            // explicit flag commands
            if (flags.setC) begin
                status.flags.c <= 1'b1;
            end
            if (flags.clrC) begin
                status.flags.c <= 1'b0;
            end
            if (flags.setD) begin
                status.flags.d <= 1'b1;
            end
            if (flags.clrD) begin
                status.flags.d <= 1'b0;
            end

            // bit 5 reads as one at all times
            status.flags.one <= 1'b1;
        end
    end

endmodule

/* hdl/progCounter.sv */
// program counter
// steps once per finished command with wrap, or loads the
// zero-extended operand on a jump

`timescale 1ns/1ns

module progCounter #(
    parameter int pcWidth = 8
) (
    input  logic                 rstAll,
    input  logic                 reset,
    input  logic                 commit,
    input  logic                 pcLoad,
    input  cpuPkg::dataWord      loadValue,
    output logic [pcWidth-1:0]   pcOut
);

    logic [pcWidth-1:0] pcNext;

    always_comb begin
        if (pcLoad) begin
            pcNext = pcWidth'(loadValue);
        end else begin
            // wraps at 2**pcWidth
            pcNext = pcOut + {{(pcWidth-1){1'b0}}, 1'b1};
        end
    end

    always_ff @(posedge rstAll) begin
        if (reset) begin
            pcOut <= '0;
        end else if (commit) begin
            pcOut <= pcNext;
        end
    end

endmodule

/* hdl/instrSequencer.sv */
// instruction sequencer
// accepts one command at a time, decodes its kind into a registered control
// word and steps IDLE, OPERAND, EXECUTE and WRITEBACK with phase strobes

`timescale 1ns/1ns

module instrSequencer (
    input  logic            rstAll,
    input  logic            reset,
    input  cpuPkg::cmdWord  cmd,
    input  logic            cmdValid,
    output logic            busy,
    output logic            done,
    output cpuPkg::ctrlWord ctrl,
    output logic            latchOp,
    output logic            execEn,
    output logic            commit
);
    import cpuPkg::*;

    typedef enum logic [1:0] {stIdle, stOperand, stExecute, stWriteback} seqState;

    seqState state;
    ctrlWord decoded;
    logic    accept;

    // cmdValid while busy is simply dropped
    assign accept  = cmdValid && (state == stIdle);
    assign busy    = (state != stIdle);
    assign latchOp = (state == stOperand);
    assign execEn  = (state == stExecute);
    assign commit  = (state == stWriteback);

    always_comb begin
        decoded = '0;
        decoded.alu = aluPass;
        case (cmd.op)
            opAdc: begin
                decoded.alu        = aluAdd;
                decoded.dest       = destA;
                decoded.flags.updNZ = 1'b1;
                decoded.flags.updC  = 1'b1;
                decoded.flags.updV  = 1'b1;
            end
            opAnd:   {decoded.alu, decoded.dest, decoded.flags.updNZ} = {aluAnd, destA, 1'b1};
            opEor:   {decoded.alu, decoded.dest, decoded.flags.updNZ} = {aluEor, destA, 1'b1};
            opOra:   {decoded.alu, decoded.dest, decoded.flags.updNZ} = {aluOr, destA, 1'b1};
            opLsr: begin
                decoded.alu        = aluLsr;
                decoded.dest       = destA;
                decoded.flags.updNZ = 1'b1;
                decoded.flags.updC  = 1'b1;
            end
            // loads are zero ORed with the operand
            opLda:   {decoded.alu, decoded.src, decoded.dest} = {aluOr, srcZero, destA};
            opLdx:   {decoded.alu, decoded.src, decoded.dest} = {aluOr, srcZero, destX};
            opLdy:   {decoded.alu, decoded.src, decoded.dest} = {aluOr, srcZero, destY};
            opTax:   {decoded.src, decoded.dest} = {srcA, destX};
            opTay:   {decoded.src, decoded.dest} = {srcA, destY};
            opTxa:   {decoded.src, decoded.dest} = {srcX, destA};
            opTya:   {decoded.src, decoded.dest} = {srcY, destA};
            opSec:   decoded.flags.setC = 1'b1;
            opClc:   decoded.flags.clrC = 1'b1;
            opSed:   decoded.flags.setD = 1'b1;
            opCld:   decoded.flags.clrD = 1'b1;
            opJmp:   decoded.pcLoad = 1'b1;
            default: decoded.dest = destNone;
        endcase
        // loads and transfers also set N and Z
        if ((cmd.op >= opLda) && (cmd.op <= opTya)) begin
            decoded.flags.updNZ = 1'b1;
        end
    end

    always_ff @(posedge rstAll) begin
        if (reset) begin
            state <= stIdle;
            done  <= 1'b0;
            ctrl  <= '0;
        end else begin
            // one cycle pulse, in the cycle busy drops
            done <= (state == stWriteback);
            case (state)
                stIdle: begin
                    if (accept) begin
                        state <= stOperand;
                        ctrl  <= decoded;
                    end
                end
                stOperand: state <= stExecute;
                stExecute: state <= stWriteback;
                default:   state <= stIdle;
            endcase
        end
    end

endmodule

/* hdl/cpuCore.sv */
// cpu core top level
// connects the sequencer, data registers, arithmetic unit, status register
// and program counter of the accumulator datapath

`timescale 1ns/1ns

module cpuCore #(
    parameter int pcWidth = 8
) (
    input  logic               rstAll,
    input  logic               reset,
    input  cpuPkg::cmdWord     cmd,
    input  logic               cmdValid,
    output logic               busy,
    output logic               done,
    output cpuPkg::dataWord    accOut,
    output cpuPkg::dataWord    xOut,
    output cpuPkg::dataWord    yOut,
    output cpuPkg::statusWord  status,
    output logic [pcWidth-1:0] pcOut
);
    import cpuPkg::*;

    ctrlWord  ctrl;
    logic     latchOp;
    logic     execEn;
    logic     commit;
    dataWord  aSide;
    dataWord  operand;
    aluResult result;

    instrSequencer uSeq (
        .rstAll(rstAll), .reset(reset), .cmd(cmd), .cmdValid(cmdValid),
        .busy(busy), .done(done), .ctrl(ctrl),
        .latchOp(latchOp), .execEn(execEn), .commit(commit)
    );

    // operand is sampled from cmd in the cycle after acceptance
    dataRegs uRegs (
        .rstAll(rstAll), .reset(reset), .latchOp(latchOp), .commit(commit),
        .operandIn(cmd.operand), .ctrl(ctrl), .result(result),
        .aSide(aSide), .operand(operand),
        .accOut(accOut), .xOut(xOut), .yOut(yOut)
    );

    arithUnit uAlu (
        .rstAll(rstAll), .reset(reset), .execEn(execEn), .op(ctrl.alu),
        .aSide(aSide), .operand(operand), .status(status), .result(result)
    );

    statusReg uStatus (
        .rstAll(rstAll), .reset(reset), .commit(commit),
        .flags(ctrl.flags), .result(result), .status(status)
    );

    progCounter #(.pcWidth(pcWidth)) uPc (
        .rstAll(rstAll), .reset(reset), .commit(commit),
        .pcLoad(ctrl.pcLoad), .loadValue(operand), .pcOut(pcOut)
    );

endmodule

/* dv/cpuCore_chk.sv */
// cpu core protocol checks
// concurrent assertions on the sequencer strobes and the status word,
// bound into the sequencer and the status register

`timescale 1ns/1ns

module cpuCoreChk #(
    parameter bit checkStrobes = 1'b1
) (
    input logic              rstAll,
    input logic              reset,
    input logic              cmdValid,
    input logic              busy,
    input logic              done,
    input cpuPkg::statusWord status
);

    // each bound copy checks only the side its host module drives
    if (checkStrobes) begin : strobeChecks
        donePulse: assert property (@(posedge rstAll) disable iff (reset) done |=> !done)
            else $error("done stayed high for more than one cycle");

        // accept edge, then three quiet edges, done sampled high on the fourth
        doneLatency: assert property (@(posedge rstAll) disable iff (reset)
            (cmdValid && !busy) |-> ##1 !done ##1 !done ##1 !done ##1 done)
            else $error("done did not follow acceptance by exactly 3 cycles");

        idleAfterReset: assert property (@(posedge rstAll) reset |=> (!busy && !done))
            else $error("busy or done high right after reset");
    end else begin : statusChecks
        statusBitFive: assert property (@(posedge rstAll) disable iff (reset) status.raw[5])
            else $error("status bit 5 dropped");
    end

endmodule

// the sequencer has no status word and the status register no strobes,
// so the unused side is tied off
bind instrSequencer cpuCoreChk #(.checkStrobes(1'b1)) seqChk (
    .rstAll(rstAll), .reset(reset), .cmdValid(cmdValid), .busy(busy), .done(done),
    .status(cpuPkg::statusReset)
);

bind statusReg cpuCoreChk #(.checkStrobes(1'b0)) statusChk (
    .rstAll(rstAll), .reset(reset), .cmdValid(1'b0), .busy(1'b0), .done(1'b0),
    .status(status)
);

/* dv/cpuCoreTb.sv */
// cpu core testbench
// random and directed command streams against a reference model of the
// accumulator datapath, checked after every done pulse

`timescale 1ns/1ns

module cpuCoreTb;
    import cpuPkg::*;

    localparam int pcWidth     = 8;
    localparam int clkPeriod   = 4;
    localparam int resetCycles = 4;
    localparam int randCount   = 40;
    localparam int bcdCount    = 20;
    localparam int moveRounds  = 10;
    localparam int numCmds     = randCount + 2 + 3 * bcdCount + 11 * moveRounds + 9;
    localparam int doneLimit   = 8;
    localparam int watchdogNs  = (numCmds * 5 + resetCycles) * clkPeriod;

    typedef struct packed {
        dataWord            a;
        dataWord            x;
        dataWord            y;
        statusWord          st;
        logic [pcWidth-1:0] pc;
    } modelState;

    logic               rstAll;
    logic               reset;
    cmdWord             cmd;
    logic               cmdValid;
    logic               busy;
    logic               done;
    dataWord            accOut;
    dataWord            xOut;
    dataWord            yOut;
    statusWord          status;
    logic [pcWidth-1:0] pcOut;
    modelState          model;
    modelState          expQ[$];

    cpuCore #(.pcWidth(pcWidth)) dut (
        .rstAll(rstAll), .reset(reset), .cmd(cmd), .cmdValid(cmdValid),
        .busy(busy), .done(done), .accOut(accOut), .xOut(xOut), .yOut(yOut),
        .status(status), .pcOut(pcOut)
    );

    always #(clkPeriod / 2) rstAll = ~rstAll;

    task automatic abortRun();
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkData(input string what, input dataWord got, input dataWord exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            abortRun();
        end
    endtask

    task automatic checkStatus(input statusWord got, input statusWord exp);
        if (got.raw !== exp.raw) begin
            $display("FAIL %0t: status got %h expected %h", $time, got.raw, exp.raw);
            abortRun();
        end
    endtask

    task automatic checkPc(input logic [pcWidth-1:0] got, input logic [pcWidth-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: pc got %h expected %h", $time, got, exp);
            abortRun();
        end
    endtask

    task automatic checkBit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
            abortRun();
        end
    endtask

    // next architectural state for one command
    function automatic modelState refModel(input modelState s, input cmdWord c);
        modelState  n;
        logic [8:0] sum;
        logic [4:0] lowNib;
        dataWord    adj;
        logic       decC;
        logic       setNZ;
        n     = s;
        setNZ = 1'b1;
        case (c.op)
            opAdc: begin
                sum    = {1'b0, s.a} + {1'b0, c.operand} + {8'd0, s.st.flags.c};
                lowNib = {1'b0, s.a[3:0]} + {1'b0, c.operand[3:0]} + {4'd0, s.st.flags.c};
                n.st.flags.v = (s.a[7] == c.operand[7]) && (sum[7] != s.a[7]);
                n.a          = sum[7:0];
                n.st.flags.c = sum[8];
                if (s.st.flags.d) begin
                    adj  = sum[7:0];
                    decC = sum[8] || (sum[7:0] > 8'h99);
                    if ((sum[3:0] > 4'd9) || lowNib[4]) begin
                        adj = adj + 8'h06;
                    end
                    if (decC) begin
                        adj = adj + 8'h60;
                    end
                    n.a          = adj;
                    n.st.flags.c = decC;
                end
            end
            opAnd: n.a = s.a & c.operand;
            opEor: n.a = s.a ^ c.operand;
            opOra: n.a = s.a | c.operand;
            opLsr: begin
                n.st.flags.c = s.a[0];
                n.a          = s.a >> 1;
            end
            opLda: n.a = c.operand;
            opLdx: n.x = c.operand;
            opLdy: n.y = c.operand;
            opTax: n.x = s.a;
            opTay: n.y = s.a;
            opTxa: n.a = s.x;
            opTya: n.a = s.y;
            default: setNZ = 1'b0;
        endcase
        case (c.op)
            opSec: n.st.flags.c = 1'b1;
            opClc: n.st.flags.c = 1'b0;
            opSed: n.st.flags.d = 1'b1;
            opCld: n.st.flags.d = 1'b0;
            default: ;
        endcase
        if (setNZ) begin
            // N and Z follow whichever register was written
            if ((c.op == opLdx) || (c.op == opTax)) begin
                n.st.flags.n = n.x[7];
                n.st.flags.z = (n.x == 8'h00);
            end else if ((c.op == opLdy) || (c.op == opTay)) begin
                n.st.flags.n = n.y[7];
                n.st.flags.z = (n.y == 8'h00);
            end else begin
                n.st.flags.n = n.a[7];
                n.st.flags.z = (n.a == 8'h00);
            end
        end
        if (c.op == opJmp) begin
            n.pc = pcWidth'(c.operand);
        end else begin
            n.pc = s.pc + pcWidth'(1);
        end
        return n;
    endfunction

    // true decimal sum of two BCD bytes, carry in bit 8
    function automatic logic [8:0] bcdSum(input dataWord x, input dataWord y, input logic c);
        int total;
        total = int'(x[7:4]) * 10 + int'(x[3:0]) + int'(y[7:4]) * 10 + int'(y[3:0]) + int'(c);
        return {total >= 100, 4'((total % 100) / 10), 4'(total % 10)};
    endfunction

    // zero and 80 show up often to hit the Z and N edges
    function automatic dataWord randByte();
        case ($urandom % 8)
            0: return 8'h00;
            1: return 8'h80;
            default: return dataWord'($urandom);
        endcase
    endfunction

    function automatic dataWord randBcd();
        return {4'($urandom % 10), 4'($urandom % 10)};
    endfunction

    // issue one command and wait for its done pulse
    task automatic runCmd(input opKind op, input dataWord val, input logic pulseBusy);
        cmdWord c;
        int     cycles;
        c.op      = op;
        c.operand = val;
        if (busy) begin
            $display("sequencer still busy when the next command was due");
            abortRun();
        end
        model = refModel(model, c);
        expQ.push_back(model);
        cmd      = c;
        cmdValid = 1'b1;
        @(posedge rstAll);
        #1;
        // taken at that edge, a pulse while busy must be dropped
        cmdValid = pulseBusy;
        if (pulseBusy) begin
            cmd.op = opTax;
        end
        cycles = 0;
        do begin
            @(posedge rstAll);
            #1;
            cmdValid = 1'b0;
            cycles++;
        end while (!done && (cycles < doneLimit));
        if (!done) begin
            $display("no done pulse within %0d cycles of an accepted command", doneLimit);
            abortRun();
        end
        if (cycles != 3) begin
            $display("FAIL %0t: done came %0d cycles after accept, expected 3", $time, cycles);
            abortRun();
        end
    endtask

    always @(negedge rstAll) begin : compareOutputs
        modelState exp;
        if (!reset && done) begin
            if (expQ.size() == 0) begin
                $display("done pulse seen with no command outstanding");
                abortRun();
            end else begin
                exp = expQ.pop_front();
                checkData("A", accOut, exp.a);
                checkData("X", xOut, exp.x);
                checkData("Y", yOut, exp.y);
                checkStatus(status, exp.st);
                checkPc(pcOut, exp.pc);
            end
        end
    end

    initial begin
        #(watchdogNs);
        $display("watchdog timeout, the command stream did not finish in time");
        abortRun();
    end

    initial begin
        dataWord    a;
        dataWord    b;
        logic       cin;
        logic [8:0] bcd;
        rstAll     = 1'b0;
        reset      = 1'b1;
        cmd        = '0;
        cmdValid   = 1'b0;
        model        = '0;
        model.st.raw = statusReset;
        void'($urandom(32'hedbd));
        repeat (resetCycles) @(posedge rstAll);
        #1;
        reset = 1'b0;

        checkBit("busy after reset", busy, 1'b0);
        checkBit("done after reset", done, 1'b0);
        checkData("A after reset", accOut, 8'h00);
        checkData("X after reset", xOut, 8'h00);
        checkData("Y after reset", yOut, 8'h00);
        checkStatus(status, model.st);
        checkPc(pcOut, '0);

        // binary ALU mix
        repeat (randCount) begin
            case ($urandom % 6)
                0: runCmd(opAdc, randByte(), 1'b0);
                1: runCmd(opAnd, randByte(), 1'b0);
                2: runCmd(opEor, randByte(), 1'b0);
                3: runCmd(opOra, randByte(), 1'b0);
                4: runCmd(opLsr, randByte(), 1'b0);
                default: runCmd(opLda, randByte(), 1'b0);
            endcase
        end

        // decimal add on valid BCD
        runCmd(opSed, 8'h00, 1'b0);
        repeat (bcdCount) begin
            a   = randBcd();
            b   = randBcd();
            cin = 1'($urandom % 2);
            if (cin) begin
                runCmd(opSec, 8'h00, 1'b0);
            end else begin
                runCmd(opClc, 8'h00, 1'b0);
            end
            runCmd(opLda, a, 1'b0);
            runCmd(opAdc, b, 1'b0);
            bcd = bcdSum(a, b, cin);
            checkData("decimal sum", accOut, bcd[7:0]);
            checkBit("decimal carry", status.flags.c, bcd[8]);
        end
        runCmd(opCld, 8'h00, 1'b0);

        // loads, transfers and flag commands
        repeat (moveRounds) begin
            runCmd(opLdx, randByte(), 1'b0);
            runCmd(opLdy, randByte(), 1'b0);
            runCmd(opTxa, 8'h00, 1'b0);
            runCmd(opTay, 8'h00, 1'b0);
            runCmd(opLda, randByte(), 1'b0);
            runCmd(opTax, 8'h00, 1'b0);
            runCmd(opTya, 8'h00, 1'b0);
            runCmd(opSec, 8'h00, 1'b0);
            runCmd(opClc, 8'h00, 1'b0);
            runCmd(opSed, 8'h00, 1'b0);
            runCmd(opCld, 8'h00, 1'b0);
        end

        // pc wrap, jumps and cmdValid pulses while busy
        runCmd(opJmp, 8'hfd, 1'b0);
        repeat (5) runCmd(opNop, randByte(), 1'b1);
        runCmd(opJmp, randByte(), 1'b1);
        runCmd(opLda, randByte(), 1'b1);
        runCmd(opAdc, randByte(), 1'b0);

        @(negedge rstAll);
        #1;
        if (expQ.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("commands left without a compare at the end of the run");
            abortRun();
        end
    end

endmodule

/* src.f */
hdl/cpuPkg.sv
hdl/arithUnit.sv
hdl/dataRegs.sv
hdl/statusReg.sv
hdl/progCounter.sv
hdl/instrSequencer.sv
hdl/cpuCore.sv
dv/cpuCore_chk.sv
dv/cpuCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the cpu core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module cpuCoreTb \
    -f src.f \
    -o VcpuCoreTb

./obj_dir/VcpuCoreTb 2>&1 | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation reported errors"
    exit 1
fi

echo "simulation passed"
